//--- source/peak_capture_consts.svh
`ifndef PEAK_CAPTURE_CONSTS_SVH
`define PEAK_CAPTURE_CONSTS_SVH

//////////////////////////////////////////////////
// beat geometry
//////////////////////////////////////////////////

// channels per beat
`define PC_NUM_CHANNELS 4

// bits per signed channel sample
`define PC_CHANNEL_WIDTH 16

// whole beat, channel 0 in the low bits
`define PC_BEAT_WIDTH (`PC_NUM_CHANNELS * `PC_CHANNEL_WIDTH)

//////////////////////////////////////////////////
// detection and capture window
//////////////////////////////////////////////////

// peak when a magnitude is strictly above this
`define PC_PEAK_THRESHOLD 12000

// beats per capture window
`define PC_BURST_LENGTH 8

// history depth, window opens this many beats before the peak
`define PC_PRE_TRIGGER 4

`endif

//--- source/peak_capture_pkg.sv
`default_nettype none

`include "peak_capture_consts.svh"

package peak_capture_pkg;

  //////////////////////////////////////////////////
  // per-channel scalars
  //////////////////////////////////////////////////

  // raw two's complement sample
  typedef logic signed [`PC_CHANNEL_WIDTH-1:0] sample_t;

  // absolute value, saturated at the top
  typedef logic [`PC_CHANNEL_WIDTH-1:0] magnitude_t;

  //////////////////////////////////////////////////
  // whole beat
  //////////////////////////////////////////////////

  // one beat, two views of the same bits
  // flat for storage and ports, ch for per-channel math
  typedef union packed {
    logic [`PC_BEAT_WIDTH-1:0]           flat;
    sample_t [`PC_NUM_CHANNELS-1:0]      ch;
  } quad_word_u;

  // four magnitudes, index 0 in the low bits
  typedef magnitude_t [`PC_NUM_CHANNELS-1:0] quad_mag_t;

endpackage

`default_nettype wire

//--- source/sample_stream_if.sv
`default_nettype none

// stage-to-stage beat stream
// carries the raw beat plus its precomputed magnitudes
interface sample_stream_if
  import peak_capture_pkg::*;
();

  // handshake
  logic       valid;
  logic       ready;

  // payload, held stable while valid and not ready
  quad_word_u data;
  quad_mag_t  mag;

  // producer side
  modport source (
    output valid,
    input  ready,
    output data,
    output mag
  );

  // consumer side
  modport sink (
    input  valid,
    output ready,
    input  data,
    input  mag
  );

endinterface

`default_nettype wire

//--- source/channel_abs.sv
`default_nettype none

`include "peak_capture_consts.svh"

module channel_abs
  import peak_capture_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic               in_valid,
  output logic               in_ready,
  input  quad_word_u         in_data,
  sample_stream_if.source    out
);

  //////////////////////////////////////////////////
  // saturating magnitude, one per channel
  //////////////////////////////////////////////////

  // most negative sample has no positive twin
  localparam sample_t    SAMPLE_MIN = {1'b1, {(`PC_CHANNEL_WIDTH-1){1'b0}}};
  localparam magnitude_t MAG_MAX    = {1'b0, {(`PC_CHANNEL_WIDTH-1){1'b1}}};

  quad_mag_t  mag_next;

  always_comb begin
    sample_t s;
    for (int i = 0; i < `PC_NUM_CHANNELS; i++) begin
      s = in_data.ch[i];
      if (s == SAMPLE_MIN) begin
        mag_next[i] = MAG_MAX;
      end else if (s < 0) begin
        mag_next[i] = magnitude_t'(-s);
      end else begin
        mag_next[i] = magnitude_t'(s);
      end
    end
  end

  //////////////////////////////////////////////////
  // one-entry pipeline slice
  //////////////////////////////////////////////////

  logic       valid_r;
  quad_word_u data_r;
  quad_mag_t  mag_r;

  // take a beat when empty or when the sink drains us this cycle
  assign in_ready = !valid_r || out.ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_r <= 1'b0;
    end else if (in_ready) begin
      valid_r <= in_valid;
    end
  end

  // payload only moves on an accepted beat
  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      data_r <= in_data;
      mag_r  <= mag_next;
    end
  end

  assign out.valid = valid_r;
  assign out.data  = data_r;
  assign out.mag   = mag_r;

endmodule

`default_nettype wire

//--- source/sample_delay_line.sv
`default_nettype none

module sample_delay_line #(
  parameter int WIDTH = 64,
  parameter int DEPTH = 4
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             shift,
  input  logic [WIDTH-1:0] din,
  output logic [WIDTH-1:0] dout
);

  //////////////////////////////////////////////////
  // register chain
  //////////////////////////////////////////////////

  // stage 0 holds the newest beat
  // stage DEPTH-1 holds the beat DEPTH shifts back
  logic [WIDTH-1:0] stage [DEPTH];

  always_ff @(posedge clk) begin
    if (rst) begin
      // history starts out as zero beats
      for (int i = 0; i < DEPTH; i++) begin
        stage[i] <= '0;
      end
    end else if (shift) begin
      stage[0] <= din;
      for (int i = 1; i < DEPTH; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  //////////////////////////////////////////////////
  // tap
  //////////////////////////////////////////////////

  // combinational read of the oldest stage
  // sampled by the caller on the same edge that shifts din in
  assign dout = stage[DEPTH-1];

endmodule

`default_nettype wire

//--- source/burst_trigger.sv
`default_nettype none

`include "peak_capture_consts.svh"

module burst_trigger
  import peak_capture_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  sample_stream_if.sink             in,
  output logic                      m_valid,
  input  logic                      m_ready,
  output logic [`PC_BEAT_WIDTH-1:0] m_data,
  output logic                      m_last
);

  //////////////////////////////////////////////////
  // sizes
  //////////////////////////////////////////////////

  // counter must hold the full burst length
  localparam int               CNT_W     = $clog2(`PC_BURST_LENGTH + 1);
  localparam logic [CNT_W-1:0] BURST_LEN = CNT_W'(`PC_BURST_LENGTH);
  localparam magnitude_t       THRESHOLD = magnitude_t'(`PC_PEAK_THRESHOLD);

  //////////////////////////////////////////////////
  // input handshake
  //////////////////////////////////////////////////

  logic                      m_valid_r;
  logic [`PC_BEAT_WIDTH-1:0] m_data_r;
  logic                      m_last_r;
  logic                      accept;

  // free slot, or the slot empties this cycle
  assign in.ready = !m_valid_r || m_ready;
  assign accept   = in.valid && in.ready;

  //////////////////////////////////////////////////
  // pre-trigger history
  //////////////////////////////////////////////////

  logic [`PC_BEAT_WIDTH-1:0] delayed;

  // every accepted beat enters history, in window or not
  sample_delay_line #(
    .WIDTH (`PC_BEAT_WIDTH),
    .DEPTH (`PC_PRE_TRIGGER)
  ) u_delay (
    .clk   (clk),
    .rst   (rst),
    .shift (accept),
    .din   (in.data.flat),
    .dout  (delayed)
  );

  //////////////////////////////////////////////////
  // threshold test and window count
  //////////////////////////////////////////////////

  logic             is_peak;
  logic [CNT_W-1:0] count_r;
  logic [CNT_W-1:0] count_cur;
  logic             in_window;

  // any channel strictly above threshold
  always_comb begin
    is_peak = 1'b0;
    for (int i = 0; i < `PC_NUM_CHANNELS; i++) begin
      if (in.mag[i] > THRESHOLD) begin
        is_peak = 1'b1;
      end
    end
  end

  // a peak restarts the window, else keep what is left
  assign count_cur = is_peak ? BURST_LEN : count_r;
  assign in_window = (count_cur != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      count_r <= '0;
    end else if (accept && in_window) begin
      count_r <= count_cur - 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////

  // in-window beats load, everything else just drains
  always_ff @(posedge clk) begin
    if (rst) begin
      m_valid_r <= 1'b0;
      m_last_r  <= 1'b0;
    end else if (accept && in_window) begin
      m_valid_r <= 1'b1;
      m_last_r  <= (count_cur == CNT_W'(1));
    end else if (m_ready) begin
      m_valid_r <= 1'b0;
      m_last_r  <= 1'b0;
    end
  end

  // delayed beat as seen before this edge's shift
  always_ff @(posedge clk) begin
    if (accept && in_window) begin
      m_data_r <= delayed;
    end
  end

  assign m_valid = m_valid_r;
  assign m_data  = m_data_r;
  assign m_last  = m_last_r;

endmodule

`default_nettype wire

//--- source/peak_capture_top.sv
`default_nettype none

`include "peak_capture_consts.svh"

module peak_capture_top (
  input  logic                      clk,
  input  logic                      rst,

  // upstream beats
  input  logic                      s_valid,
  output logic                      s_ready,
  input  logic [`PC_BEAT_WIDTH-1:0] s_data,

  // captured windows
  output logic                      m_valid,
  input  logic                      m_ready,
  output logic [`PC_BEAT_WIDTH-1:0] m_data,
  output logic                      m_last
);

  //////////////////////////////////////////////////
  // magnitude stage to trigger stage
  //////////////////////////////////////////////////

  // beat plus magnitudes, one cycle after s_valid/s_ready
  sample_stream_if mag_stream ();

  //////////////////////////////////////////////////
  // stage 1, register beat and magnitudes
  //////////////////////////////////////////////////

  channel_abs u_channel_abs (
    .clk      (clk),
    .rst      (rst),
    .in_valid (s_valid),
    .in_ready (s_ready),
    .in_data  (s_data),
    .out      (mag_stream.source)
  );

  //////////////////////////////////////////////////
  // stage 2, threshold, window, output register
  //////////////////////////////////////////////////

  // back-pressure from m_ready ripples up through mag_stream.ready
  burst_trigger u_burst_trigger (
    .clk     (clk),
    .rst     (rst),
    .in      (mag_stream.sink),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_data  (m_data),
    .m_last  (m_last)
  );

endmodule

`default_nettype wire

//--- test/peak_capture_tb.sv
`default_nettype none

`include "peak_capture_consts.svh"

module peak_capture_tb
  import peak_capture_pkg::*;
();

  //////////////////////////////////////////////////
  // sizes and timing
  //////////////////////////////////////////////////

  localparam int CW = `PC_CHANNEL_WIDTH;
  localparam int BW = `PC_BEAT_WIDTH;
  localparam int DRIVE_DELAY = 2;
  localparam int READY_DELAY = 1;
  localparam int TIMEOUT_CYCLES = 1000;
  localparam sample_t SAMPLE_MIN = {1'b1, {(CW-1){1'b0}}};
  localparam int MAG_MAX = (1 << (CW - 1)) - 1;

  // one expected output beat
  typedef struct {
    logic [BW-1:0] data;
    logic          last;
    int            edge_no;
    bit            timed;
  } expect_t;

  logic          clk;
  logic          rst;
  logic          s_valid;
  logic          s_ready;
  logic [BW-1:0] s_data;
  logic          m_valid;
  logic          m_ready;
  logic [BW-1:0] m_data;
  logic          m_last;

  integer        seed;
  int            edge_count;
  bit            stall_en;
  bit            check_latency;
  logic [BW-1:0] acc_q[$];
  expect_t       exp_q[$];

  peak_capture_top DUT (
    .clk     (clk),
    .rst     (rst),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .s_data  (s_data),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_data  (m_data),
    .m_last  (m_last)
  );

  always #10 clk = ~clk;

  // rising edges since time zero
  always @(posedge clk) begin
    edge_count <= edge_count + 1;
  end

  // downstream sink, random stalls when enabled
  always @(posedge clk) begin
    #READY_DELAY;
    if (stall_en) begin
      m_ready = (($random(seed) & 3) != 0);
    end else begin
      m_ready = 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // failure reporting
  //////////////////////////////////////////////////

  task automatic abort_run();
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_value(input string what, input logic [BW-1:0] got,
                             input logic [BW-1:0] expected);
    if (got !== expected) begin
      $display("[ERROR] %0t %s: got %h, expected %h", $time, what, got, expected);
      abort_run();
    end
  endtask

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  // absolute value, most negative clamps to the top
  function automatic int magnitude_of(input sample_t s);
    int v;
    v = s;
    if (v < 0) begin
      v = -v;
    end
    if (v > MAG_MAX) begin
      v = MAG_MAX;
    end
    return v;
  endfunction

  function automatic bit beat_is_peak(input logic [BW-1:0] beat);
    for (int i = 0; i < `PC_NUM_CHANNELS; i++) begin
      if (magnitude_of(sample_t'(beat[i*CW +: CW])) > `PC_PEAK_THRESHOLD) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  // replay the window rule over accepted beats 0..idx
  // returns 1 when beat idx yields an output beat
  function automatic bit window_output(input int idx, output logic [BW-1:0] data,
                                       output logic last);
    int count;
    count = 0;
    data  = '0;
    last  = 1'b0;
    for (int n = 0; n < idx; n++) begin
      if (beat_is_peak(acc_q[n])) begin
        count = `PC_BURST_LENGTH;
      end
      if (count > 0) begin
        count--;
      end
    end
    if (beat_is_peak(acc_q[idx])) begin
      count = `PC_BURST_LENGTH;
    end
    if (count == 0) begin
      return 1'b0;
    end
    // missing history reads as zero
    if (idx >= `PC_PRE_TRIGGER) begin
      data = acc_q[idx - `PC_PRE_TRIGGER];
    end
    last = (count == 1);
    return 1'b1;
  endfunction

  //////////////////////////////////////////////////
  // scoreboard, sampled mid-cycle where all is stable
  //////////////////////////////////////////////////

  always @(negedge clk) begin : scoreboard
    expect_t       entry;
    logic [BW-1:0] exp_data;
    logic          exp_last;
    // input handshake completes on the coming edge
    if (!rst && s_valid && s_ready) begin
      acc_q.push_back(s_data);
      if (window_output(acc_q.size() - 1, exp_data, exp_last)) begin
        entry.data    = exp_data;
        entry.last    = exp_last;
        entry.edge_no = edge_count + 1;
        entry.timed   = check_latency;
        exp_q.push_back(entry);
      end
    end
    // output handshake, one model entry per beat
    if (!rst && m_valid && m_ready) begin
      if (exp_q.size() == 0) begin
        $display("output beat appeared at %0t with no beat expected by the model", $time);
        abort_run();
      end
      entry = exp_q.pop_front();
      check_value("m_data", m_data, entry.data);
      check_value("m_last", BW'(m_last), BW'(entry.last));
      if (entry.timed) begin
        check_value("latency", BW'(edge_count + 1 - entry.edge_no), BW'(2));
      end
    end
  end

  //////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////

  function automatic int rand_below(input int n);
    return ($random(seed) & 32'h7fff_ffff) % n;
  endfunction

  // small samples, with an occasional peak or near miss
  function automatic logic [BW-1:0] random_beat(input int peak_odds);
    logic [BW-1:0] beat;
    int            ch;
    for (int i = 0; i < `PC_NUM_CHANNELS; i++) begin
      beat[i*CW +: CW] = sample_t'($random(seed) % 2001);
    end
    if (peak_odds != 0 && rand_below(peak_odds) == 0) begin
      ch = rand_below(`PC_NUM_CHANNELS);
      case (rand_below(5))
        0: beat[ch*CW +: CW] = sample_t'(`PC_PEAK_THRESHOLD);
        1: beat[ch*CW +: CW] = sample_t'(-`PC_PEAK_THRESHOLD);
        2: beat[ch*CW +: CW] = sample_t'(`PC_PEAK_THRESHOLD + 1);
        3: beat[ch*CW +: CW] = SAMPLE_MIN;
        default: beat[ch*CW +: CW] = sample_t'($random(seed));
      endcase
    end
    return beat;
  endfunction

  function automatic logic [BW-1:0] with_channel(input logic [BW-1:0] beat, input int ch,
                                                 input sample_t value);
    beat[ch*CW +: CW] = value;
    return beat;
  endfunction

  task automatic idle(input int cycles);
    s_valid = 1'b0;
    repeat (cycles) begin
      @(posedge clk);
      #DRIVE_DELAY;
    end
  endtask

  // hold the beat until the handshake edge
  task automatic send_beat(input logic [BW-1:0] beat);
    int waited;
    waited  = 0;
    s_valid = 1'b1;
    s_data  = beat;
    @(negedge clk);
    while (!s_ready) begin
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        $display("timed out waiting for s_ready to accept a beat");
        abort_run();
      end
      @(negedge clk);
    end
    @(posedge clk);
    #DRIVE_DELAY;
    s_valid = 1'b0;
  endtask

  task automatic send_small(input int beats);
    repeat (beats) begin
      send_beat(random_beat(0));
    end
  endtask

  task automatic random_phase(input int beats, input int max_gap);
    for (int i = 0; i < beats; i++) begin
      idle(rand_below(max_gap + 1));
      send_beat(random_beat(12));
    end
  endtask

  // all model entries consumed and the output register empty
  task automatic wait_for_drain();
    int waited;
    waited = 0;
    @(negedge clk);
    while (exp_q.size() != 0 || m_valid) begin
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        $display("timed out waiting for the expected output beats to drain");
        abort_run();
      end
      @(negedge clk);
    end
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    seed          = 32'ha0d7_ad94;
    clk           = 1'b0;
    rst           = 1'b1;
    s_valid       = 1'b0;
    s_data        = '0;
    m_ready       = 1'b1;
    edge_count    = 0;
    stall_en      = 1'b0;
    check_latency = 1'b1;

    repeat (4) @(posedge clk);
    #DRIVE_DELAY;
    rst = 1'b0;
    @(negedge clk);
    check_value("s_ready after reset", BW'(s_ready), BW'(1));
    check_value("m_valid after reset", BW'(m_valid), BW'(0));
    @(posedge clk);
    #DRIVE_DELAY;

    // peak in the first beats, history reads as zero
    send_small(2);
    send_beat(with_channel(random_beat(0), 1, sample_t'(20000)));
    send_small(12);
    wait_for_drain();

    // quiet stream with gaps, nothing comes out
    for (int i = 0; i < 24; i++) begin
      idle(rand_below(3));
      send_beat(random_beat(0));
    end
    wait_for_drain();

    // one isolated peak
    send_small(6);
    send_beat(with_channel(random_beat(0), 2, sample_t'(-15000)));
    send_small(12);

    // threshold edges, equal does not trigger
    send_beat(with_channel(random_beat(0), 0, sample_t'(`PC_PEAK_THRESHOLD)));
    send_beat(with_channel(random_beat(0), 3, sample_t'(-`PC_PEAK_THRESHOLD)));
    send_small(12);
    send_beat(with_channel(random_beat(0), 0, sample_t'(`PC_PEAK_THRESHOLD + 1)));
    send_small(12);
    send_beat(with_channel(random_beat(0), 3, SAMPLE_MIN));
    send_small(12);

    // second peak restarts an open window
    send_beat(with_channel(random_beat(0), 1, sample_t'(14000)));
    send_small(3);
    send_beat(with_channel(random_beat(0), 2, sample_t'(13000)));
    send_small(12);
    wait_for_drain();

    // random gaps, latency still fixed
    random_phase(150, 2);
    wait_for_drain();

    // random gaps and downstream stalls
    check_latency = 1'b0;
    stall_en      = 1'b1;
    random_phase(200, 2);

    // every expected beat must come out before the end
    wait_for_drain();

    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- peak_capture.f
+incdir+source
source/peak_capture_pkg.sv
source/sample_stream_if.sv
source/channel_abs.sv
source/sample_delay_line.sv
source/burst_trigger.sv
source/peak_capture_top.sv
test/peak_capture_tb.sv

//--- build.sh
#!/bin/sh
# compile the peak capture testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
  -f peak_capture.f \
  --top-module peak_capture_tb \
  -o peak_capture_sim

# keep the log even when the simulation exits with an error
status=0
./obj_dir/peak_capture_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -qx "Done: no errors" sim.log; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed, exit status $status"
exit 1
